// File: Makefile
# Verilator flow for the UART peripheral

VERILATOR ?= verilator
TOP       ?= uart_tb
FILELIST  ?= compile.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= Simulation passed
VFLAGS    ?= --timing --assert

SOURCES := $(wildcard source/*.sv tb/*.sv include/*.svh)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

$(OBJ_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)

# The log decides the result, not the simulator's exit status
sim: $(OBJ_DIR)/V$(TOP)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -q "^$(PASS_MSG)$$" $(LOG) || { echo "Pass message not found in $(LOG)"; exit 1; }
	@echo "Pass message found in $(LOG)"

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: compile.f
+incdir+include
source/uart_bus_pkg.sv
source/uart_reg_pkg.sv
source/uart_tx.sv
source/uart_rx.sv
source/uart_regs.sv
source/uart_periph_top.sv
tb/uart_tb_clk.sv
tb/uart_sva.sv
tb/uart_tb.sv

// File: include/uart_defs.svh
`ifndef UART_DEFS_SVH
`define UART_DEFS_SVH

// Data bus word width
`define UART_XLEN     32

// Serial character and divisor widths
`define UART_DATA_W   8
`define UART_DIV_W    8

// Clocks per bit after reset
`define UART_BAUD_RST 8

// Register index taken from addr[4:2]
`define UART_REG_AW   3

`endif

// File: source/uart_bus_pkg.sv
`default_nettype none
`include "uart_defs.svh"

package uart_bus_pkg;

    // Word and byte address on the data bus
    typedef logic [`UART_XLEN-1:0] bus_data_t;
    typedef logic [`UART_XLEN-1:0] bus_addr_t;

    // Master side of the four-phase handshake
    typedef struct packed {
        logic      req;
        logic      w_en;
        bus_addr_t addr;
        bus_data_t w_data;
    } dbus_req_s;

    // Slave side, r_data valid while ack is high
    typedef struct packed {
        logic      ack;
        bus_data_t r_data;
    } dbus_rsp_s;

endpackage

`default_nettype wire

// File: source/uart_periph_top.sv
`timescale 1ns/1ns
`default_nettype none

module uart_periph_top (
    input  wire logic                    clk,
    input  wire logic                    rst_n,
    input  wire uart_bus_pkg::dbus_req_s dbus_req_i,
    input  wire logic                    sel_i,
    output uart_bus_pkg::dbus_rsp_s      dbus_rsp_o,
    output logic                         irq_o,
    input  wire logic                    rxd_i,
    output logic                         txd_o
);

    // Transmit path
    logic                     tx_start;
    uart_reg_pkg::uart_byte_t tx_byte;
    logic                     two_stop;
    logic                     tx_busy;

    // Receive path
    logic                     rx_valid;
    uart_reg_pkg::uart_byte_t rx_byte;
    logic                     frame_err;

    // Shared by both directions
    uart_reg_pkg::uart_div_t  baud_div;

    uart_regs i_regs (
        .clk         (clk),
        .rst_n       (rst_n),
        .dbus_req_i  (dbus_req_i),
        .sel_i       (sel_i),
        .dbus_rsp_o  (dbus_rsp_o),
        .irq_o       (irq_o),
        .tx_start_o  (tx_start),
        .tx_byte_o   (tx_byte),
        .two_stop_o  (two_stop),
        .baud_div_o  (baud_div),
        .tx_busy_i   (tx_busy),
        .rx_valid_i  (rx_valid),
        .rx_byte_i   (rx_byte),
        .frame_err_i (frame_err)
    );

    uart_tx i_tx (
        .clk         (clk),
        .rst_n       (rst_n),
        .start_i     (tx_start),
        .data_i      (tx_byte),
        .two_stop_i  (two_stop),
        .baud_div_i  (baud_div),
        .busy_o      (tx_busy),
        .txd_o       (txd_o)
    );

    uart_rx i_rx (
        .clk         (clk),
        .rst_n       (rst_n),
        .rxd_i       (rxd_i),
        .baud_div_i  (baud_div),
        .valid_o     (rx_valid),
        .data_o      (rx_byte),
        .frame_err_o (frame_err)
    );

endmodule

`default_nettype wire

// File: source/uart_reg_pkg.sv
`default_nettype none
`include "uart_defs.svh"

package uart_reg_pkg;

    typedef logic [`UART_DATA_W-1:0] uart_byte_t;

    // Clocks per serial bit, never below 4
    typedef logic [`UART_DIV_W-1:0] uart_div_t;

    // Register map
    typedef enum logic [`UART_REG_AW-1:0] {
        REG_DATA    = 3'd0,
        REG_IE      = 3'd1,
        REG_STATUS  = 3'd2,
        REG_LCTRL   = 3'd3,
        REG_BAUD    = 3'd4,
        REG_SCRATCH = 3'd7
    } uart_reg_e;

    // STATUS bits, also the IE mask layout
    localparam int ST_RX_FULL   = 0;
    localparam int ST_FRAME_ERR = 1;
    localparam int ST_TX_IDLE   = 5;

    // LCTRL bits
    localparam int LCTRL_TWO_STOP = 0;

    typedef enum logic [1:0] {TX_IDLE, TX_START, TX_DATA, TX_STOP} tx_state_e;
    typedef enum logic [1:0] {RX_IDLE, RX_START, RX_DATA, RX_STOP} rx_state_e;

endpackage

`default_nettype wire

// File: source/uart_regs.sv
`timescale 1ns/1ns
`default_nettype none
`include "uart_defs.svh"

module uart_regs (
    input  wire logic                     clk,
    input  wire logic                     rst_n,

    input  wire uart_bus_pkg::dbus_req_s  dbus_req_i,
    input  wire logic                     sel_i,
    output uart_bus_pkg::dbus_rsp_s       dbus_rsp_o,
    output logic                          irq_o,

    output logic                          tx_start_o,
    output uart_reg_pkg::uart_byte_t      tx_byte_o,
    output logic                          two_stop_o,
    output uart_reg_pkg::uart_div_t       baud_div_o,
    input  wire logic                     tx_busy_i,

    input  wire logic                     rx_valid_i,
    input  wire uart_reg_pkg::uart_byte_t rx_byte_i,
    input  wire logic                     frame_err_i
);

    uart_reg_pkg::uart_reg_e  reg_idx;
    logic                     access;
    logic                     wr_access;
    logic                     rd_access;
    logic                     tx_accept;
    uart_reg_pkg::uart_byte_t wr_byte;
    uart_reg_pkg::uart_div_t  wr_div;
    uart_reg_pkg::uart_byte_t rd_byte;
    uart_reg_pkg::uart_byte_t status;

    logic                     ack_q;
    uart_bus_pkg::bus_data_t  r_data_q;

    uart_reg_pkg::uart_byte_t data_tx_q;
    uart_reg_pkg::uart_byte_t data_rx_q;
    uart_reg_pkg::uart_byte_t ie_q;
    uart_reg_pkg::uart_byte_t lctrl_q;
    uart_reg_pkg::uart_byte_t scratch_q;
    uart_reg_pkg::uart_div_t  baud_q;

    logic                     rx_full_q;
    logic                     frame_err_q;
    logic                     tx_idle_q;
    logic                     tx_start_q;
    logic                     irq_q;

    // Bus decode
    // --------------------
    assign reg_idx   = uart_reg_pkg::uart_reg_e'(dbus_req_i.addr[`UART_REG_AW+1:2]);
    assign wr_byte   = dbus_req_i.w_data[`UART_DATA_W-1:0];
    assign wr_div    = dbus_req_i.w_data[`UART_DIV_W-1:0];

    // One access per handshake, taken on the cycle before ack rises
    assign access    = dbus_req_i.req && sel_i && !ack_q;
    assign wr_access = access && dbus_req_i.w_en;
    assign rd_access = access && !dbus_req_i.w_en;

    // A DATA write is only passed on while the transmitter is free
    assign tx_accept = wr_access && (reg_idx == uart_reg_pkg::REG_DATA)
                       && !tx_busy_i && !tx_start_q;

    always_comb begin
        status = '0;
        status[uart_reg_pkg::ST_RX_FULL]   = rx_full_q;
        status[uart_reg_pkg::ST_FRAME_ERR] = frame_err_q;
        status[uart_reg_pkg::ST_TX_IDLE]   = tx_idle_q;
    end

    always_comb begin
        case (reg_idx)
            uart_reg_pkg::REG_DATA:    rd_byte = data_rx_q;
            uart_reg_pkg::REG_IE:      rd_byte = ie_q;
            uart_reg_pkg::REG_STATUS:  rd_byte = status;
            uart_reg_pkg::REG_LCTRL:   rd_byte = lctrl_q;
            uart_reg_pkg::REG_BAUD:    rd_byte = baud_q;
            uart_reg_pkg::REG_SCRATCH: rd_byte = scratch_q;
            default:                   rd_byte = '0;
        endcase
    end

    // Four-phase slave
    // --------------------
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ack_q <= 1'b0;
        end else if (access) begin
            ack_q <= 1'b1;
        end else if (!dbus_req_i.req) begin
            // Release one cycle after the master drops req
            ack_q <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (access) begin
            if (dbus_req_i.w_en) begin
                r_data_q <= '0;
            end else begin
                r_data_q <= {{(`UART_XLEN-`UART_DATA_W){1'b0}}, rd_byte};
            end
        end
    end

    // Register file
    // --------------------
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ie_q      <= '0;
            lctrl_q   <= '0;
            baud_q    <= uart_reg_pkg::uart_div_t'(`UART_BAUD_RST);
            scratch_q <= '0;
        end else if (wr_access) begin
            // DATA, STATUS and unmapped indexes fall through here
            case (reg_idx)
                uart_reg_pkg::REG_IE:      ie_q      <= wr_byte;
                uart_reg_pkg::REG_LCTRL:   lctrl_q   <= wr_byte;
                uart_reg_pkg::REG_BAUD:    baud_q    <= wr_div;
                uart_reg_pkg::REG_SCRATCH: scratch_q <= wr_byte;
                default: begin
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (tx_accept) begin
            data_tx_q <= wr_byte;
        end
        // Newest received byte wins
        if (rx_valid_i) begin
            data_rx_q <= rx_byte_i;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            tx_start_q <= 1'b0;
        end else begin
            tx_start_q <= tx_accept;
        end
    end

    // Status and interrupt
    // --------------------
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rx_full_q   <= 1'b0;
            frame_err_q <= 1'b0;
            tx_idle_q   <= 1'b1;
            irq_q       <= 1'b0;
        end else begin
            // Set has priority over the read-clear
            if (rx_valid_i) begin
                rx_full_q <= 1'b1;
            end else if (rd_access && (reg_idx == uart_reg_pkg::REG_DATA)) begin
                rx_full_q <= 1'b0;
            end

            if (frame_err_i) begin
                frame_err_q <= 1'b1;
            end else if (rd_access && (reg_idx == uart_reg_pkg::REG_STATUS)) begin
                frame_err_q <= 1'b0;
            end

            tx_idle_q <= !tx_busy_i;
            irq_q     <= |(status & ie_q);
        end
    end

    assign dbus_rsp_o.ack    = ack_q;
    assign dbus_rsp_o.r_data = r_data_q;
    assign irq_o             = irq_q;

    assign tx_start_o = tx_start_q;
    assign tx_byte_o  = data_tx_q;
    assign two_stop_o = lctrl_q[uart_reg_pkg::LCTRL_TWO_STOP];
    assign baud_div_o = baud_q;

endmodule

`default_nettype wire

// File: source/uart_rx.sv
`timescale 1ns/1ns
`default_nettype none

module uart_rx (
    input  wire logic                     clk,
    input  wire logic                     rst_n,
    input  wire logic                     rxd_i,
    input  wire uart_reg_pkg::uart_div_t  baud_div_i,
    output logic                          valid_o,
    output uart_reg_pkg::uart_byte_t      data_o,
    output logic                          frame_err_o
);

    localparam int unsigned NBITS = $bits(uart_reg_pkg::uart_byte_t);
    localparam int unsigned IDX_W = $clog2(NBITS);
    localparam logic [IDX_W-1:0] LAST_BIT = IDX_W'(NBITS - 1);

    logic                     rxd_meta;
    logic                     rxd_sync;
    logic                     rxd_prev;
    logic                     fall;
    logic                     bit_end;

    uart_reg_pkg::rx_state_e  state_q;
    uart_reg_pkg::uart_div_t  cnt_q;
    uart_reg_pkg::uart_div_t  div_q;
    logic [IDX_W-1:0]         bit_q;
    uart_reg_pkg::uart_byte_t shift_q;
    logic                     valid_q;
    logic                     ferr_q;

    // Input synchronizer
    // --------------------
    // Held at the idle level through reset so no false start is seen
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rxd_meta <= 1'b1;
            rxd_sync <= 1'b1;
            rxd_prev <= 1'b1;
        end else begin
            rxd_meta <= rxd_i;
            rxd_sync <= rxd_meta;
            rxd_prev <= rxd_sync;
        end
    end

    assign fall    = rxd_prev && !rxd_sync;
    assign bit_end = (cnt_q == '0);

    // Sampler
    // --------------------
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state_q <= uart_reg_pkg::RX_IDLE;
            cnt_q   <= '0;
            bit_q   <= '0;
            valid_q <= 1'b0;
            ferr_q  <= 1'b0;
        end else begin
            valid_q <= 1'b0;
            ferr_q  <= 1'b0;

            // Half a bit from the edge lands in the middle of the start bit
            if (state_q == uart_reg_pkg::RX_IDLE) begin
                cnt_q <= (baud_div_i >> 1) - 1'b1;
            end else if (bit_end) begin
                cnt_q <= div_q - 1'b1;
            end else begin
                cnt_q <= cnt_q - 1'b1;
            end

            case (state_q)
                uart_reg_pkg::RX_IDLE: begin
                    if (fall) begin
                        state_q <= uart_reg_pkg::RX_START;
                    end
                end
                uart_reg_pkg::RX_START: begin
                    if (bit_end) begin
                        if (!rxd_sync) begin
                            state_q <= uart_reg_pkg::RX_DATA;
                            bit_q   <= '0;
                        end else begin
                            // Glitch, line went back high
                            state_q <= uart_reg_pkg::RX_IDLE;
                        end
                    end
                end
                uart_reg_pkg::RX_DATA: begin
                    if (bit_end) begin
                        bit_q <= bit_q + 1'b1;
                        if (bit_q == LAST_BIT) begin
                            state_q <= uart_reg_pkg::RX_STOP;
                        end
                    end
                end
                uart_reg_pkg::RX_STOP: begin
                    if (bit_end) begin
                        state_q <= uart_reg_pkg::RX_IDLE;
                        valid_q <= rxd_sync;
                        ferr_q  <= !rxd_sync;
                    end
                end
            endcase
        end
    end

    // LSB arrives first and shifts down from the top
    always_ff @(posedge clk) begin
        if ((state_q == uart_reg_pkg::RX_IDLE) && fall) begin
            div_q <= baud_div_i;
        end
        if ((state_q == uart_reg_pkg::RX_DATA) && bit_end) begin
            shift_q <= {rxd_sync, shift_q[NBITS-1:1]};
        end
    end

    assign valid_o     = valid_q;
    assign data_o      = shift_q;
    assign frame_err_o = ferr_q;

endmodule

`default_nettype wire

// File: source/uart_tx.sv
`timescale 1ns/1ns
`default_nettype none

module uart_tx (
    input  wire logic                     clk,
    input  wire logic                     rst_n,
    input  wire logic                     start_i,
    input  wire uart_reg_pkg::uart_byte_t data_i,
    input  wire logic                     two_stop_i,
    input  wire uart_reg_pkg::uart_div_t  baud_div_i,
    output logic                          busy_o,
    output logic                          txd_o
);

    localparam int unsigned NBITS = $bits(uart_reg_pkg::uart_byte_t);
    localparam int unsigned IDX_W = $clog2(NBITS);
    localparam logic [IDX_W-1:0] LAST_BIT = IDX_W'(NBITS - 1);

    uart_reg_pkg::tx_state_e  state_q;
    uart_reg_pkg::uart_div_t  cnt_q;
    uart_reg_pkg::uart_div_t  div_q;
    logic [IDX_W-1:0]         bit_q;
    uart_reg_pkg::uart_byte_t shift_q;
    logic                     two_stop_q;
    logic                     second_stop_q;
    logic                     txd_q;
    logic                     bit_end;

    assign bit_end = (cnt_q == '0);

    // Bit timing and frame sequencing
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state_q       <= uart_reg_pkg::TX_IDLE;
            cnt_q         <= '0;
            bit_q         <= '0;
            second_stop_q <= 1'b0;
        end else begin
            // Idle keeps the counter primed for the start bit
            if (state_q == uart_reg_pkg::TX_IDLE) begin
                cnt_q <= baud_div_i - 1'b1;
            end else if (bit_end) begin
                cnt_q <= div_q - 1'b1;
            end else begin
                cnt_q <= cnt_q - 1'b1;
            end

            case (state_q)
                uart_reg_pkg::TX_IDLE: begin
                    if (start_i) begin
                        state_q <= uart_reg_pkg::TX_START;
                    end
                end
                uart_reg_pkg::TX_START: begin
                    if (bit_end) begin
                        state_q <= uart_reg_pkg::TX_DATA;
                        bit_q   <= '0;
                    end
                end
                uart_reg_pkg::TX_DATA: begin
                    if (bit_end) begin
                        bit_q <= bit_q + 1'b1;
                        if (bit_q == LAST_BIT) begin
                            state_q       <= uart_reg_pkg::TX_STOP;
                            second_stop_q <= two_stop_q;
                        end
                    end
                end
                uart_reg_pkg::TX_STOP: begin
                    if (bit_end) begin
                        if (second_stop_q) begin
                            second_stop_q <= 1'b0;
                        end else begin
                            state_q <= uart_reg_pkg::TX_IDLE;
                        end
                    end
                end
            endcase
        end
    end

    // Frame settings are latched with the byte
    always_ff @(posedge clk) begin
        if (start_i && (state_q == uart_reg_pkg::TX_IDLE)) begin
            shift_q    <= data_i;
            div_q      <= baud_div_i;
            two_stop_q <= two_stop_i;
        end else if ((state_q == uart_reg_pkg::TX_DATA) && bit_end) begin
            shift_q <= shift_q >> 1;
        end
    end

    // Registered line, one cycle behind the state
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            txd_q <= 1'b1;
        end else begin
            case (state_q)
                uart_reg_pkg::TX_START: txd_q <= 1'b0;
                uart_reg_pkg::TX_DATA:  txd_q <= shift_q[0];
                default:                txd_q <= 1'b1;
            endcase
        end
    end

    assign busy_o = (state_q != uart_reg_pkg::TX_IDLE);
    assign txd_o  = txd_q;

endmodule

`default_nettype wire

// File: tb/uart_sva.sv
`timescale 1ns/1ns
`default_nettype none

module uart_sva (
    input wire logic                    clk,
    input wire logic                    rst_n,
    input wire uart_bus_pkg::dbus_req_s dbus_req_i,
    input wire uart_bus_pkg::dbus_rsp_s dbus_rsp_i,
    input wire logic                    tx_idle_i,
    input wire logic                    txd_i
);

    logic req;
    logic ack;

    // Number of assertion failures so far
    int unsigned fail_cnt = 0;

    assign req = dbus_req_i.req;
    assign ack = dbus_rsp_i.ack;

    // Handshake
    // --------------------
    ack_needs_req: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(ack) |-> $past(req))
        else begin
            fail_cnt++;
            $error("ack rose without a pending req");
        end

    ack_held: assert property (@(posedge clk) disable iff (!rst_n)
        (ack && req) |=> ack)
        else begin
            fail_cnt++;
            $error("ack dropped while req was still high");
        end

    // Serial line
    // --------------------
    line_idle: assert property (@(posedge clk) disable iff (!rst_n)
        tx_idle_i |-> txd_i)
        else begin
            fail_cnt++;
            $error("txd low while STATUS.TX_IDLE is set");
        end

endmodule

bind uart_periph_top uart_sva i_sva (
    .clk        (clk),
    .rst_n      (rst_n),
    .dbus_req_i (dbus_req_i),
    .dbus_rsp_i (dbus_rsp_o),
    .tx_idle_i  (i_regs.tx_idle_q),
    .txd_i      (txd_o)
);

`default_nettype wire

// File: tb/uart_tb.sv
`timescale 1ns/1ns
`default_nettype none
`include "uart_defs.svh"

module uart_tb;

    localparam int MAX_DIV = 9;
    // Req is seen one edge after it is driven and ack follows one cycle later
    localparam int ACK_EDGES = 2;
    localparam uart_bus_pkg::bus_data_t FULL = 32'hFFFF_FFFF;
    localparam uart_bus_pkg::bus_data_t M_RX_FULL = 32'(1) << uart_reg_pkg::ST_RX_FULL;
    localparam uart_bus_pkg::bus_data_t M_FERR = 32'(1) << uart_reg_pkg::ST_FRAME_ERR;
    localparam uart_bus_pkg::bus_data_t M_IDLE = 32'(1) << uart_reg_pkg::ST_TX_IDLE;

    typedef enum logic [2:0] {OP_WR, OP_RD, OP_POLL, OP_IRQ, OP_BAD} op_e;

    typedef struct packed {
        op_e                     op;
        logic [`UART_REG_AW-1:0] idx;
        uart_bus_pkg::bus_data_t data;
        uart_bus_pkg::bus_data_t exp;
        uart_bus_pkg::bus_data_t mask;
    } row_s;

    logic                    clk;
    logic                    rst_n;
    uart_bus_pkg::dbus_req_s dbus_req;
    logic                    sel;
    uart_bus_pkg::dbus_rsp_s dbus_rsp;
    logic                    irq;
    logic                    txd;
    logic                    rxd;
    logic                    line_force;
    logic                    line_val;

    row_s                    table_q[$];
    uart_reg_pkg::uart_div_t cur_div;
    integer                  seed;
    int                      cycles = 0;
    int                      cycle_limit = 0;

    uart_tb_clk i_clk (
        .clk_o   (clk),
        .rst_n_o (rst_n)
    );

    // Loopback unless the testbench drives the line itself
    assign rxd = line_force ? line_val : txd;

    uart_periph_top i_dut (
        .clk        (clk),
        .rst_n      (rst_n),
        .dbus_req_i (dbus_req),
        .sel_i      (sel),
        .dbus_rsp_o (dbus_rsp),
        .irq_o      (irq),
        .rxd_i      (rxd),
        .txd_o      (txd)
    );

    // Table construction
    // --------------------
    function automatic void add_row(op_e op, logic [`UART_REG_AW-1:0] idx,
                                    uart_bus_pkg::bus_data_t data,
                                    uart_bus_pkg::bus_data_t exp,
                                    uart_bus_pkg::bus_data_t mask);
        row_s r;
        r.op   = op;
        r.idx  = idx;
        r.data = data;
        r.exp  = exp;
        r.mask = mask;
        table_q.push_back(r);
    endfunction

    // Send one byte and read it back through the receiver
    function automatic void add_loopback(uart_reg_pkg::uart_byte_t b);
        add_row(OP_POLL, uart_reg_pkg::REG_STATUS, '0, M_IDLE, M_IDLE);
        add_row(OP_WR, uart_reg_pkg::REG_DATA, 32'(b), '0, '0);
        add_row(OP_POLL, uart_reg_pkg::REG_STATUS, '0, M_RX_FULL, M_RX_FULL);
        add_row(OP_RD, uart_reg_pkg::REG_DATA, '0, 32'(b), FULL);
        add_row(OP_RD, uart_reg_pkg::REG_STATUS, '0, '0, M_RX_FULL);
    endfunction

    function automatic void build_table();
        uart_reg_pkg::uart_div_t div;

        // Reset values
        add_row(OP_RD, uart_reg_pkg::REG_BAUD, '0, 32'(`UART_BAUD_RST), FULL);
        add_row(OP_RD, uart_reg_pkg::REG_SCRATCH, '0, '0, FULL);
        add_row(OP_RD, uart_reg_pkg::REG_STATUS, '0, M_IDLE, FULL);
        add_row(OP_IRQ, '0, '0, '0, 32'h1);

        // Read-back with the upper bus bits dropped
        add_row(OP_WR, uart_reg_pkg::REG_SCRATCH, 32'h1234_56A5, '0, '0);
        add_row(OP_RD, uart_reg_pkg::REG_SCRATCH, '0, 32'hA5, FULL);
        add_row(OP_WR, uart_reg_pkg::REG_IE, 32'h5A, '0, '0);
        add_row(OP_RD, uart_reg_pkg::REG_IE, '0, 32'h5A, FULL);
        add_row(OP_WR, uart_reg_pkg::REG_IE, 32'h0, '0, '0);
        add_row(OP_WR, uart_reg_pkg::REG_LCTRL, 32'hC3, '0, '0);
        add_row(OP_RD, uart_reg_pkg::REG_LCTRL, '0, 32'hC3, FULL);
        add_row(OP_WR, uart_reg_pkg::REG_LCTRL, 32'h0, '0, '0);
        add_row(OP_WR, uart_reg_pkg::REG_BAUD, 32'h37, '0, '0);
        add_row(OP_RD, uart_reg_pkg::REG_BAUD, '0, 32'h37, FULL);
        add_row(OP_WR, 3'd5, 32'hFF, '0, '0);
        add_row(OP_RD, 3'd5, '0, '0, FULL);
        add_row(OP_RD, 3'd6, '0, '0, FULL);
        add_row(OP_WR, uart_reg_pkg::REG_STATUS, 32'hFF, '0, '0);
        add_row(OP_RD, uart_reg_pkg::REG_STATUS, '0, M_IDLE, FULL);

        // Loopback over divisor and stop-bit settings
        for (int d = 0; d < 2; d++) begin
            div = (d == 0) ? uart_reg_pkg::uart_div_t'(4)
                           : uart_reg_pkg::uart_div_t'(MAX_DIV);
            for (int s = 0; s < 2; s++) begin
                add_row(OP_POLL, uart_reg_pkg::REG_STATUS, '0, M_IDLE, M_IDLE);
                add_row(OP_WR, uart_reg_pkg::REG_BAUD, 32'(div), '0, '0);
                add_row(OP_WR, uart_reg_pkg::REG_LCTRL, 32'(s), '0, '0);
                add_loopback(8'h55);
                add_loopback(8'h00);
                add_loopback(8'hFF);
                add_loopback(8'($random(seed)));
                add_loopback(8'($random(seed)));
            end
        end

        // Interrupt on receive and then masked
        add_row(OP_WR, uart_reg_pkg::REG_IE, M_RX_FULL, '0, '0);
        add_row(OP_POLL, uart_reg_pkg::REG_STATUS, '0, M_IDLE, M_IDLE);
        add_row(OP_WR, uart_reg_pkg::REG_DATA, 32'h3C, '0, '0);
        add_row(OP_POLL, uart_reg_pkg::REG_STATUS, '0, M_RX_FULL, M_RX_FULL);
        add_row(OP_IRQ, '0, '0, 32'h1, 32'h1);
        add_row(OP_RD, uart_reg_pkg::REG_DATA, '0, 32'h3C, FULL);
        add_row(OP_IRQ, '0, '0, '0, 32'h1);
        add_row(OP_WR, uart_reg_pkg::REG_IE, 32'h0, '0, '0);
        add_row(OP_POLL, uart_reg_pkg::REG_STATUS, '0, M_IDLE, M_IDLE);
        add_row(OP_WR, uart_reg_pkg::REG_DATA, 32'hC3, '0, '0);
        add_row(OP_POLL, uart_reg_pkg::REG_STATUS, '0, M_RX_FULL, M_RX_FULL);
        add_row(OP_IRQ, '0, '0, '0, 32'h1);
        add_row(OP_RD, uart_reg_pkg::REG_DATA, '0, 32'hC3, FULL);

        // Frame with a low stop bit and the error cleared by a STATUS read
        add_row(OP_POLL, uart_reg_pkg::REG_STATUS, '0, M_IDLE, M_IDLE);
        add_row(OP_BAD, '0, 32'hA7, '0, '0);
        add_row(OP_RD, uart_reg_pkg::REG_STATUS, '0, M_FERR, M_FERR | M_RX_FULL);
        add_row(OP_RD, uart_reg_pkg::REG_STATUS, '0, '0, M_FERR | M_RX_FULL);

        // Second write lands while the transmitter is busy
        add_row(OP_POLL, uart_reg_pkg::REG_STATUS, '0, M_IDLE, M_IDLE);
        add_row(OP_WR, uart_reg_pkg::REG_DATA, 32'hA1, '0, '0);
        add_row(OP_WR, uart_reg_pkg::REG_DATA, 32'h5E, '0, '0);
        add_row(OP_POLL, uart_reg_pkg::REG_STATUS, '0, M_RX_FULL, M_RX_FULL);
        add_row(OP_RD, uart_reg_pkg::REG_DATA, '0, 32'hA1, FULL);
        add_row(OP_POLL, uart_reg_pkg::REG_STATUS, '0, M_IDLE, M_IDLE);
        add_row(OP_RD, uart_reg_pkg::REG_STATUS, '0, M_IDLE, M_IDLE | M_RX_FULL);
    endfunction

    // Bus and line drivers
    // --------------------
    task automatic bus_access(input logic we, input logic [`UART_REG_AW-1:0] idx,
                              input uart_bus_pkg::bus_data_t wdata,
                              output uart_bus_pkg::bus_data_t rdata);
        uart_bus_pkg::dbus_req_s r;
        int                      waits;
        r.req    = 1'b1;
        r.w_en   = we;
        r.addr   = uart_bus_pkg::bus_addr_t'(idx) << 2;
        r.w_data = wdata;
        @(posedge clk);
        dbus_req <= r;
        sel      <= 1'b1;
        waits = 0;
        do begin
            @(posedge clk);
            waits++;
        end while (!dbus_rsp.ack);
        check_value("ack rise latency in clock edges", 32'(waits), 32'(ACK_EDGES));
        rdata = dbus_rsp.r_data;
        dbus_req <= '0;
        sel      <= 1'b0;
        waits = 0;
        do begin
            @(posedge clk);
            waits++;
        end while (dbus_rsp.ack);
        check_value("ack release latency in clock edges", 32'(waits), 32'(ACK_EDGES));
    endtask

    task automatic send_bad_frame(input uart_reg_pkg::uart_byte_t b,
                                  input uart_reg_pkg::uart_div_t div);
        logic [9:0] frame;
        // Start bit first and the stop bit forced low
        frame = {1'b0, b, 1'b0};
        @(posedge clk);
        line_val   <= 1'b1;
        line_force <= 1'b1;
        for (int j = 0; j < 10; j++) begin
            repeat (div) @(posedge clk);
            line_val <= frame[j];
        end
        repeat (div) @(posedge clk);
        line_val <= 1'b1;
        repeat (2 * div) @(posedge clk);
        line_force <= 1'b0;
    endtask

    task automatic check_value(input string what, input uart_bus_pkg::bus_data_t got,
                               input uart_bus_pkg::bus_data_t exp);
        if (got !== exp) begin
            $display("** Error at %0t ns: %s: got 0x%08h, expected 0x%08h",
                     $time, what, got, exp);
            $display("Simulation failed");
            $fatal(1, "Stopped at the first mismatch");
        end
    endtask

    task automatic apply_row(input row_s row, input int n);
        uart_bus_pkg::bus_data_t rd;
        case (row.op)
            OP_WR: begin
                bus_access(1'b1, row.idx, row.data, rd);
                if (row.idx == uart_reg_pkg::REG_BAUD) begin
                    cur_div = row.data[`UART_DIV_W-1:0];
                end
            end
            OP_RD: begin
                bus_access(1'b0, row.idx, '0, rd);
                check_value($sformatf("row %0d read of index %0d", n, row.idx),
                            rd & row.mask, row.exp & row.mask);
            end
            OP_POLL: begin
                do begin
                    bus_access(1'b0, row.idx, '0, rd);
                end while ((rd & row.mask) !== (row.exp & row.mask));
            end
            OP_IRQ: begin
                @(posedge clk);
                check_value($sformatf("row %0d irq level", n), 32'(irq),
                            row.exp & row.mask);
            end
            default: begin
                send_bad_frame(row.data[`UART_DATA_W-1:0], cur_div);
            end
        endcase
    endtask

    // Run control
    // --------------------
    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (i_dut.i_sva.fail_cnt != 0) begin
            $display("An assertion on the DUT failed");
            $display("Simulation failed");
            $fatal(1, "Run stopped by a failed assertion");
        end else if ((cycle_limit != 0) && (cycles >= cycle_limit)) begin
            $display("Timeout: the tests did not finish within %0d clock cycles", cycles);
            $display("Simulation failed");
            $fatal(1, "Run stopped by the cycle limit");
        end
    end

    initial begin
        dbus_req   = '0;
        sel        = 1'b0;
        line_force = 1'b0;
        line_val   = 1'b1;
        cur_div    = uart_reg_pkg::uart_div_t'(`UART_BAUD_RST);
        seed       = 59927;
        build_table();
        // Every row gets a budget of twelve worst-case frames
        cycle_limit = table_q.size() * 12 * 11 * MAX_DIV;
        wait (rst_n === 1'b1);
        foreach (table_q[i]) begin
            apply_row(table_q[i], i);
        end
        repeat (4) @(posedge clk);
        $display("Simulation passed");
        $finish;
    end

endmodule

`default_nettype wire

// File: tb/uart_tb_clk.sv
`timescale 1ns/1ns
`default_nettype none

module uart_tb_clk #(
    parameter int PERIOD_NS  = 4,
    parameter int RST_CYCLES = 3
) (
    output logic clk_o,
    output logic rst_n_o
);

    initial begin
        clk_o = 1'b0;
        forever #(PERIOD_NS / 2) clk_o = ~clk_o;
    end

    // Synchronous reset, released on a rising edge
    initial begin
        rst_n_o = 1'b0;
        repeat (RST_CYCLES) @(posedge clk_o);
        rst_n_o <= 1'b1;
    end

endmodule

`default_nettype wire
